//--- include/fcvt_settings.svh
// Float/integer converter constants
// Widths, exponent bias and internal datapath sizes shared by all blocks
`ifndef FCVT_SETTINGS_SVH
`define FCVT_SETTINGS_SVH

`define FCVT_WIDTH    32  // Operand and result word
`define FCVT_EXP_BITS 8   // binary32 exponent field
`define FCVT_MAN_BITS 23  // Stored mantissa, no hidden bit
`define FCVT_BIAS     127

// Internal mantissa holds a whole integer or the mantissa plus hidden bit
`define FCVT_MAN_W    32
`define FCVT_EXP_W    10  // Signed, covers smallest subnormal
`define FCVT_LZC_W    5   // log2 of the internal mantissa width
`define FCVT_TAG_W    4   // Operation id carried down the pipe

`endif

//--- src/fcvt_pkg.sv
// Float/integer converter types
// Words, exponents, op and rounding encodings and the pipeline payloads

`include "fcvt_settings.svh"

package fcvt_pkg;

  typedef logic        [`FCVT_WIDTH-1:0] data_t;
  typedef logic        [`FCVT_MAN_W-1:0] man_t;
  typedef logic signed [`FCVT_EXP_W-1:0] exp_t;   // Unbiased, two's complement
  typedef logic        [`FCVT_LZC_W:0]   shamt_t; // One spare bit for shifts past the word
  typedef logic        [`FCVT_TAG_W-1:0] tag_t;

  typedef enum logic {
    CVT_F2I = 1'b0,
    CVT_I2F = 1'b1
  } cvt_op_e;

  // Same encoding as the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } rnd_mode_e;

  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_subnormal;
  } fp_class_t;

  typedef struct packed {
    logic nv; // Invalid
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // ------------------------------------------------------------------
  // Pipeline payloads

  typedef struct packed {
    data_t     operand;
    cvt_op_e   op;
    logic      is_unsigned; // Integer side is unsigned
    rnd_mode_e rnd_mode;
    tag_t      tag;
  } fcvt_req_t;

  typedef struct packed {
    logic      sign;
    exp_t      exponent;  // Unbiased
    man_t      mantissa;  // MSB set unless zero
    logic      mant_zero;
    fp_class_t cls;       // Only meaningful for float sources
    cvt_op_e   op;
    logic      is_unsigned;
    rnd_mode_e rnd_mode;
    tag_t      tag;
  } fcvt_norm_t;

  typedef struct packed {
    data_t   result;
    status_t status;
    tag_t    tag;
  } fcvt_resp_t;

endpackage

//--- src/fcvt_lzc.sv
// Leading-zero counter over the internal mantissa
// Log-depth search, halves the window at each level

`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_lzc (
  input  fcvt_pkg::man_t   value_i,
  output fcvt_pkg::shamt_t count_o,
  output logic             empty_o
);

  import fcvt_pkg::*;

  logic [`FCVT_LZC_W-1:0] cnt; // One bit resolved per level

  always_comb begin : count_zeros
    man_t win;
    win = value_i;
    cnt = '0;
    // Widest window first, 16 then 8, 4, 2, 1
    for (int lvl = `FCVT_LZC_W - 1; lvl >= 0; lvl--) begin
      if ((win >> (`FCVT_MAN_W - (1 << lvl))) == '0) begin
        cnt[lvl] = 1'b1;
        win      = win << (1 << lvl); // Drop the zero half
      end
    end
  end

  assign count_o = shamt_t'(cnt);
  assign empty_o = ~|value_i; // Count saturates at all ones here

endmodule

//--- src/fcvt_stage_reg.sv
// Pipeline register stage with valid/ready handshake
// Advances when downstream is ready or when it only holds a bubble

`timescale 1ns/100ps

module fcvt_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Empty stage takes new data without waiting on downstream
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i; // Bubble in when nothing offered
    end
  end

  // Load only on an accepted item, held otherwise
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

//--- src/fcvt_unpack_norm.sv
// Operand unpack and normalisation
// Classifies a binary32 source or takes an integer magnitude, then
// left-aligns the mantissa and derives the unbiased exponent

`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_unpack_norm (
  input  fcvt_pkg::fcvt_req_t  req_i,
  output fcvt_pkg::fcvt_norm_t norm_o
);

  import fcvt_pkg::*;

  // Zero bits above the hidden bit in the internal mantissa
  localparam int unsigned MAN_PAD = `FCVT_MAN_W - `FCVT_MAN_BITS - 1;

  logic                      src_is_float;
  logic                      f_sign;
  logic [`FCVT_EXP_BITS-1:0] f_exp;
  logic [`FCVT_MAN_BITS-1:0] f_man;
  logic                      exp_zero;
  logic                      exp_ones;
  logic                      man_zero;
  fp_class_t                 f_cls;
  logic                      int_sign;
  data_t                     int_mag;
  man_t                      enc_man;   // Before alignment
  shamt_t                    lz_cnt;
  logic                      enc_zero;
  exp_t                      lz_s;
  exp_t                      fp_exp;
  exp_t                      int_exp;

  assign src_is_float = (req_i.op == CVT_F2I);

  // ------------------------------------------------------------------
  // Float fields and class

  assign f_sign   = req_i.operand[`FCVT_WIDTH-1];
  assign f_exp    = req_i.operand[`FCVT_MAN_BITS +: `FCVT_EXP_BITS];
  assign f_man    = req_i.operand[`FCVT_MAN_BITS-1:0];
  assign exp_zero = (f_exp == '0);
  assign exp_ones = (f_exp == '1);
  assign man_zero = (f_man == '0);

  assign f_cls.is_zero      = exp_zero & man_zero;
  assign f_cls.is_subnormal = exp_zero & ~man_zero;
  assign f_cls.is_inf       = exp_ones & man_zero;
  assign f_cls.is_nan       = exp_ones & ~man_zero;
  assign f_cls.is_snan      = exp_ones & ~man_zero & ~f_man[`FCVT_MAN_BITS-1]; // Quiet bit clear

  // Integer magnitude, unsigned sources are never negative
  assign int_sign = req_i.operand[`FCVT_WIDTH-1] & ~req_i.is_unsigned;
  assign int_mag  = int_sign ? -req_i.operand : req_i.operand;

  // Hidden bit only for normal numbers
  assign enc_man = src_is_float ? {{MAN_PAD{1'b0}}, ~exp_zero, f_man} : int_mag;

  // ------------------------------------------------------------------
  // Normalisation

  fcvt_lzc u_lzc (
    .value_i (enc_man),
    .count_o (lz_cnt),
    .empty_o (enc_zero)
  );

  assign lz_s = exp_t'(lz_cnt);

  // Subnormals sit at exponent 1, pad offsets the shift count
  assign fp_exp = exp_t'(f_exp) + exp_t'(f_cls.is_subnormal) - exp_t'(`FCVT_BIAS)
                  - lz_s + exp_t'(MAN_PAD);
  assign int_exp = exp_t'(`FCVT_MAN_W - 1) - lz_s; // Weight of the top set bit

  always_comb begin : build_norm
    norm_o.sign        = src_is_float ? f_sign : int_sign;
    norm_o.exponent    = src_is_float ? fp_exp : int_exp;
    norm_o.mantissa    = enc_man << lz_cnt;
    norm_o.mant_zero   = enc_zero;
    norm_o.cls         = src_is_float ? f_cls : '0;
    norm_o.op          = req_i.op;
    norm_o.is_unsigned = req_i.is_unsigned;
    norm_o.rnd_mode    = req_i.rnd_mode;
    norm_o.tag         = req_i.tag;
  end

endmodule

//--- src/fcvt_shift_round.sv
// Destination alignment and rounding
// Shifts the normalised mantissa into integer or binary32 position,
// flags range problems before rounding and applies the rounding mode

`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_shift_round (
  input  fcvt_pkg::fcvt_norm_t norm_i,
  output fcvt_pkg::data_t      abs_o,      // Rounded magnitude
  output logic                 round_up_o,
  output logic                 inexact_o,
  output logic                 of_pre_o,   // Out of range before rounding
  output logic                 uf_pre_o    // Tiny before rounding
);

  import fcvt_pkg::*;

  localparam int unsigned SH_W       = 2 * `FCVT_MAN_W + 1;
  localparam int unsigned INT_STICKY = 2 * `FCVT_MAN_W - `FCVT_WIDTH;          // Below R bit
  localparam int unsigned FP_STICKY  = 2 * `FCVT_MAN_W - `FCVT_MAN_BITS - 1;
  localparam exp_t        EXP_INF    = exp_t'((1 << `FCVT_EXP_BITS) - 1);

  logic                      dst_int;
  exp_t                      dst_exp;      // Rebiased for binary32
  logic [`FCVT_EXP_BITS-1:0] final_exp;
  logic [SH_W-1:0]           preshift;
  logic [SH_W-1:0]           shifted;
  shamt_t                    denorm_shamt;
  logic [`FCVT_MAN_BITS-1:0] final_man;
  data_t                     final_int;
  data_t                     pre_abs;
  logic [1:0]                fp_rs;        // Round and sticky
  logic [1:0]                int_rs;
  logic [1:0]                rs;

  assign dst_int = (norm_i.op == CVT_F2I);
  assign dst_exp = norm_i.exponent + exp_t'(`FCVT_BIAS);

  // ------------------------------------------------------------------
  // Alignment

  always_comb begin : align
    final_exp    = dst_exp[`FCVT_EXP_BITS-1:0];
    preshift     = {norm_i.mantissa, {(`FCVT_MAN_W + 1){1'b0}}}; // Left edge of shifter
    denorm_shamt = '0;
    of_pre_o     = 1'b0;
    uf_pre_o     = 1'b0;

    if (dst_int) begin
      // Binary point lands right of the integer field
      denorm_shamt = shamt_t'(exp_t'(`FCVT_WIDTH - 1) - norm_i.exponent);
      // Unsigned range reaches one bit further
      if (norm_i.exponent >= exp_t'(`FCVT_WIDTH - 1) + exp_t'(norm_i.is_unsigned)) begin
        denorm_shamt = '0;
        of_pre_o     = 1'b1;
      end else if (norm_i.exponent < exp_t'(-1)) begin
        denorm_shamt = shamt_t'(`FCVT_WIDTH + 1); // Whole value into sticky
        uf_pre_o     = 1'b1;
      end
    end else begin
      if (dst_exp >= EXP_INF) begin
        final_exp = {{(`FCVT_EXP_BITS - 1){1'b1}}, 1'b0}; // Largest normal
        preshift  = '1;                                   // With R and S set
        of_pre_o  = 1'b1;
      end else if (dst_exp < exp_t'(1) && dst_exp >= -exp_t'(`FCVT_MAN_BITS)) begin
        final_exp    = '0;
        denorm_shamt = shamt_t'(exp_t'(1) - dst_exp); // Subnormal result
        uf_pre_o     = 1'b1;
      end else if (dst_exp < -exp_t'(`FCVT_MAN_BITS)) begin
        final_exp    = '0;
        denorm_shamt = shamt_t'(`FCVT_MAN_BITS + 2);  // Keep only sticky
        uf_pre_o     = 1'b1;
      end
    end
  end

  assign shifted = preshift >> denorm_shamt;

  // Hidden bit dropped for binary32
  assign {final_man, fp_rs[1]}  = shifted[2*`FCVT_MAN_W-1 -: `FCVT_MAN_BITS+1];
  assign {final_int, int_rs[1]} = shifted[2*`FCVT_MAN_W -: `FCVT_WIDTH+1];
  assign fp_rs[0]  = |shifted[FP_STICKY-1:0];
  assign int_rs[0] = |shifted[INT_STICKY-1:0];

  assign rs      = dst_int ? int_rs : fp_rs;
  assign pre_abs = dst_int ? final_int : data_t'({final_exp, final_man});

  // ------------------------------------------------------------------
  // Rounding

  always_comb begin : round_decide
    unique case (norm_i.rnd_mode)
      RNE:     round_up_o = rs[1] & (rs[0] | pre_abs[0]); // Ties to even
      RTZ:     round_up_o = 1'b0;
      RDN:     round_up_o = (|rs) & norm_i.sign;
      RUP:     round_up_o = (|rs) & ~norm_i.sign;
      RMM:     round_up_o = rs[1];                        // Ties away
      default: round_up_o = 1'b0;
    endcase
  end

  assign inexact_o = |rs;
  assign abs_o     = pre_abs + data_t'(round_up_o); // Mantissa carry moves into exponent

endmodule

//--- src/fcvt_result_sel.sv
// Result and status selection
// Saturates out-of-range integer casts, builds binary32 words and the
// IEEE flags, and applies the sign to integer results

`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_result_sel (
  input  fcvt_pkg::fcvt_norm_t norm_i,
  input  fcvt_pkg::data_t      abs_i,
  input  logic                 round_up_i,
  input  logic                 inexact_i,
  input  logic                 of_pre_i,
  input  logic                 uf_pre_i,
  output fcvt_pkg::fcvt_resp_t resp_o
);

  import fcvt_pkg::*;

  localparam logic [`FCVT_EXP_BITS-1:0] QNAN_EXP = '1;
  localparam logic [`FCVT_MAN_BITS-1:0] QNAN_MAN = {1'b1, {(`FCVT_MAN_BITS - 1){1'b0}}};

  logic                      dst_int;
  data_t                     int_res;       // Two's complement
  data_t                     int_special;
  logic                      int_is_special;
  status_t                   int_status;
  logic [`FCVT_EXP_BITS-1:0] res_exp;
  logic                      of_post;
  logic                      uf_post;
  logic                      fp_is_special;
  data_t                     fp_res;
  status_t                   fp_status;

  assign dst_int = (norm_i.op == CVT_F2I);

  // ------------------------------------------------------------------
  // Integer destination

  assign int_res = norm_i.sign ? -abs_i : abs_i;

  always_comb begin : int_saturate
    int_special = {norm_i.is_unsigned, {(`FCVT_WIDTH - 1){1'b1}}}; // Positive max
    if (norm_i.sign && !norm_i.cls.is_nan) begin
      int_special = ~int_special; // Signed min or unsigned zero
    end
  end

  // Negative to unsigned only fails once it rounds away from zero
  assign int_is_special = norm_i.cls.is_nan | norm_i.cls.is_inf | of_pre_i |
                          (norm_i.sign & norm_i.is_unsigned & (int_res != '0));

  always_comb begin : int_flags
    int_status = '0;
    if (int_is_special) begin
      int_status.nv = 1'b1;
    end else begin
      int_status.nx = inexact_i;
    end
  end

  // ------------------------------------------------------------------
  // Float destination

  assign res_exp = abs_i[`FCVT_MAN_BITS +: `FCVT_EXP_BITS];
  assign of_post = round_up_i & (res_exp == '1); // Carry into the inf exponent
  assign uf_post = (res_exp == '0);

  assign fp_is_special = norm_i.cls.is_nan;

  always_comb begin : fp_build
    fp_status = '0;
    if (fp_is_special) begin
      fp_res        = {1'b0, QNAN_EXP, QNAN_MAN}; // Canonical quiet NaN
      fp_status.nv  = norm_i.cls.is_snan;
    end else begin
      fp_res       = norm_i.mant_zero ? '0 : {norm_i.sign, abs_i[`FCVT_WIDTH-2:0]};
      fp_status.of = of_pre_i | of_post;
      fp_status.nx = inexact_i | of_pre_i | of_post;
      fp_status.uf = (uf_pre_i | uf_post) & inexact_i; // Tiny and inexact
    end
  end

  // ------------------------------------------------------------------
  // Final select

  always_comb begin : sel_result
    resp_o.tag = norm_i.tag;
    if (dst_int) begin
      resp_o.result = int_is_special ? int_special : int_res;
      resp_o.status = int_status;
    end else begin
      resp_o.result = fp_res;
      resp_o.status = fp_status;
    end
  end

endmodule

//--- src/fcvt_top.sv
// Pipelined binary32 / 32-bit integer converter
// Unpack and normalise, register, align and round and select, register

`timescale 1ns/100ps

module fcvt_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  fcvt_pkg::fcvt_req_t  req_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output fcvt_pkg::fcvt_resp_t resp_o
);

  import fcvt_pkg::*;

  fcvt_norm_t norm_d;
  fcvt_norm_t norm_q;
  logic       norm_valid;
  logic       norm_ready;  // Back-pressure from output stage
  data_t      rnd_abs;
  logic       rnd_up;
  logic       rnd_nx;
  logic       rnd_of;
  logic       rnd_uf;
  fcvt_resp_t resp_d;

  // ------------------------------------------------------------------
  // Stage 1, normalise

  fcvt_unpack_norm u_unpack_norm (
    .req_i  (req_i),
    .norm_o (norm_d)
  );

  fcvt_stage_reg #(
    .payload_t (fcvt_norm_t)
  ) u_norm_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (norm_d),
    .valid_o (norm_valid),
    .ready_i (norm_ready),
    .data_o  (norm_q)
  );

  // ------------------------------------------------------------------
  // Stage 2, round and select

  fcvt_shift_round u_shift_round (
    .norm_i     (norm_q),
    .abs_o      (rnd_abs),
    .round_up_o (rnd_up),
    .inexact_o  (rnd_nx),
    .of_pre_o   (rnd_of),
    .uf_pre_o   (rnd_uf)
  );

  fcvt_result_sel u_result_sel (
    .norm_i     (norm_q),
    .abs_i      (rnd_abs),
    .round_up_i (rnd_up),
    .inexact_i  (rnd_nx),
    .of_pre_i   (rnd_of),
    .uf_pre_i   (rnd_uf),
    .resp_o     (resp_d)
  );

  fcvt_stage_reg #(
    .payload_t (fcvt_resp_t)
  ) u_resp_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (norm_valid),
    .ready_o (norm_ready),
    .data_i  (resp_d),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (resp_o)    // Held until taken
  );

endmodule

//--- testbench/fcvt_tb.sv
// Testbench for the binary32 / 32-bit integer converter
// Directed and random casts in both directions under random back-pressure,
// responses checked in issue order against reference rules

`timescale 1ns/100ps

module fcvt_tb;

  import fcvt_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int MAX_OPS    = 2000;
  localparam int CYC_PER_OP = 20;   // Generous bound per operation

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  fcvt_req_t  req;
  logic       out_valid;
  logic       out_ready;
  fcvt_resp_t resp;

  fcvt_resp_t exp_q[$];            // Expected responses, issue order
  int         acc_q[$];            // Cycle of each acceptance
  tag_t       tag_cnt;
  int         cycle      = 0;
  logic       ready_hold;          // Forces out_ready high
  logic       check_lat;
  logic       held_valid = 1'b0;   // Response stalled last edge
  fcvt_resp_t held_resp  = '0;

  fcvt_top dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .req_i       (req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .resp_o      (resp)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin : count_cycles
    cycle = cycle + 1;
  end

  // Random back-pressure, about 60 percent ready
  initial begin : drive_ready
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (ready_hold) begin
        out_ready = 1'b1;
      end else begin
        out_ready = ($urandom_range(9) < 6);
      end
    end
  end

  // ------------------------------------------------------------------
  // Failure reporting

  task automatic fail_value(input string name, input logic [63:0] want,
                            input logic [63:0] got);
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, want, got);
    $display("Checks failed");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic fail_event(input string what);
    $display("[FAIL] %0t ns %s", $time, what);
    $display("Checks failed");
    $fatal(1, "%s", what);
  endtask

  // ------------------------------------------------------------------
  // Reference rules

  function automatic status_t flags(input logic nv, input logic nx);
    status_t st;
    st    = '0;
    st.nv = nv;
    st.nx = nx;
    return st;
  endfunction

  // Exactly representable normal values only
  function automatic data_t f32_of_real(input real r);
    logic [63:0] d;
    d = $realtobits(r);
    if (r == 0.0) return {d[63], 31'd0};
    return {d[63], 8'(d[62:52] - 11'd896), d[51:29]}; // Rebias 1023 to 127
  endfunction

  function automatic real real_of_f32(input data_t f);
    logic [10:0] e;
    e = 11'(f[30:23]) + 11'd896;
    return $bitstoreal({f[31], e, f[22:0], 29'd0});
  endfunction

  // Integer to binary32 with ties to even, nx when low bits are lost
  function automatic data_t f32_of_int(input longint v, output logic nx);
    logic [63:0] d;
    logic [28:0] rest;          // Double mantissa bits below binary32
    logic [30:0] mag;
    d    = $realtobits(real'(v)); // Exact, 32-bit ints fit a double
    rest = d[28:0];
    nx   = (rest != '0);
    if (v == 0) return '0;
    mag = {8'(d[62:52] - 11'd896), d[51:29]};
    if (rest > 29'h1000_0000 || (rest == 29'h1000_0000 && mag[0])) begin
      mag = mag + 31'd1;        // Carry may bump the exponent
    end
    return {d[63], mag};
  endfunction

  // Integer result of +-(k + 0.5) under each mode
  function automatic int half_result(input int k, input logic neg, input rnd_mode_e mode);
    int mag;
    case (mode)
      RNE:     mag = (k % 2 == 0) ? k : k + 1; // Even neighbour
      RTZ:     mag = k;
      RDN:     mag = neg ? k + 1 : k;          // Floor
      RUP:     mag = neg ? k : k + 1;          // Ceiling
      default: mag = k + 1;                    // Away from zero
    endcase
    return neg ? -mag : mag;
  endfunction

  function automatic rnd_mode_e any_mode();
    return rnd_mode_e'(3'($urandom_range(4)));
  endfunction

  // ------------------------------------------------------------------
  // Driver

  task automatic send(input data_t operand, input cvt_op_e op, input logic uns,
                      input rnd_mode_e mode, input data_t want, input status_t want_st);
    fcvt_resp_t entry;
    @(negedge clk);
    if ($urandom_range(7) == 0) begin
      in_valid = 1'b0;          // Occasional idle cycle
      @(negedge clk);
    end
    req.operand     = operand;
    req.op          = op;
    req.is_unsigned = uns;
    req.rnd_mode    = mode;
    req.tag         = tag_cnt;
    in_valid        = 1'b1;     // Held until accepted
    do @(posedge clk); while (!in_ready);
    entry.result = want;
    entry.status = want_st;
    entry.tag    = tag_cnt;
    exp_q.push_back(entry);
    acc_q.push_back(cycle);
    tag_cnt = tag_cnt + 1'b1;
  endtask

  task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    do @(posedge clk); while (exp_q.size() != 0);
  endtask

  // ------------------------------------------------------------------
  // Response checks

  always @(posedge clk) begin : check_output
    fcvt_resp_t want;
    int         lat;
    if (!rst_n) begin
      assert (!out_valid) else fail_event("out_valid_o high during reset");
      held_valid = 1'b0;
    end else begin
      if (held_valid) begin
        assert (out_valid) else fail_event("out_valid_o dropped before the response was taken");
        assert (resp == held_resp) else fail_value("resp_o", 64'(held_resp), 64'(resp));
      end
      held_valid = out_valid && !out_ready;
      held_resp  = resp;
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else fail_event("response seen with no request outstanding");
        want = exp_q.pop_front();
        lat  = cycle - acc_q.pop_front();
        assert (resp.tag == want.tag) else fail_value("resp_o.tag", 64'(want.tag), 64'(resp.tag));
        assert (resp.result == want.result)
          else fail_value("resp_o.result", 64'(want.result), 64'(resp.result));
        assert (resp.status == want.status)
          else fail_value("resp_o.status", 64'(want.status), 64'(resp.status));
        if (check_lat) begin
          assert (lat == 2) else fail_value("latency in cycles", 64'd2, 64'(lat));
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Test groups

  task automatic i2f_exact(input int n);
    int    v;
    logic  nx;
    data_t f;
    send(32'd0, CVT_I2F, 1'b0, RNE, 32'd0, flags(1'b0, 1'b0));
    for (int i = 0; i < n; i++) begin
      v = int'($urandom_range(24'hFF_FFFF)); // Below 2^24, always exact
      if ($urandom_range(1) == 1) v = -v;
      f = f32_of_int(longint'(v), nx);
      send(data_t'(v), CVT_I2F, 1'b0, any_mode(), f, flags(1'b0, 1'b0));
    end
  endtask

  task automatic f2i_exact(input int n);
    int    v;
    logic  nx;
    logic  uns;
    data_t f;
    for (int i = 0; i < n; i++) begin
      v = int'($urandom_range(24'hFF_FFFF)) << $urandom_range(7);
      if ($urandom_range(1) == 1) v = -v;
      uns = (v >= 0) && ($urandom_range(1) == 1);
      f   = f32_of_int(longint'(v), nx);
      send(f, CVT_F2I, uns, any_mode(), data_t'(v), flags(1'b0, 1'b0));
    end
  endtask

  task automatic f2i_trunc(input int n);
    data_t f;
    real   r;
    int    t;
    for (int i = 0; i < n; i++) begin
      // Exponent -1 to 21, so fractional bits remain
      f = {1'($urandom_range(1)), 8'(126 + $urandom_range(22)), 23'($urandom)};
      r = real_of_f32(f);
      t = $rtoi(r);
      send(f, CVT_F2I, 1'b0, RTZ, data_t'(t), flags(1'b0, real'(t) != r));
    end
  endtask

  task automatic half_rounding(input int n);
    int        k;
    rnd_mode_e mode;
    data_t     f;
    real       r;
    for (int i = 0; i < n; i++) begin
      k = int'($urandom_range(999));
      r = real'(k) + 0.5;
      for (int s = 0; s < 2; s++) begin
        f = f32_of_real((s == 1) ? -r : r);
        for (int md = 0; md < 5; md++) begin
          mode = rnd_mode_e'(3'(md));
          send(f, CVT_F2I, 1'b0, mode, data_t'(half_result(k, s == 1, mode)),
               flags(1'b0, 1'b1));
        end
      end
    end
  endtask

  task automatic f2i_specials(input int n);
    status_t nv;
    int      k;
    nv = flags(1'b1, 1'b0);
    send(32'h7FC0_0000, CVT_F2I, 1'b0, RNE, 32'h7FFF_FFFF, nv); // Quiet NaN
    send(32'hFFC0_0000, CVT_F2I, 1'b1, RNE, 32'hFFFF_FFFF, nv); // Sign ignored
    send(32'h7F80_0001, CVT_F2I, 1'b0, RTZ, 32'h7FFF_FFFF, nv); // Signalling
    send(32'h7F80_0000, CVT_F2I, 1'b0, RNE, 32'h7FFF_FFFF, nv);
    send(32'h7F80_0000, CVT_F2I, 1'b1, RNE, 32'hFFFF_FFFF, nv);
    send(32'hFF80_0000, CVT_F2I, 1'b0, RUP, 32'h8000_0000, nv);
    send(32'hFF80_0000, CVT_F2I, 1'b1, RUP, 32'h0000_0000, nv);
    send(32'h4F00_0000, CVT_F2I, 1'b0, RNE, 32'h7FFF_FFFF, nv); // 2^31
    send(32'h4F80_0000, CVT_F2I, 1'b1, RNE, 32'hFFFF_FFFF, nv); // 2^32
    send(32'h60AD_78EC, CVT_F2I, 1'b1, RDN, 32'hFFFF_FFFF, nv);
    send(32'hCF40_0000, CVT_F2I, 1'b0, RTZ, 32'h8000_0000, nv); // -1.5 * 2^31
    send(32'hCF80_0000, CVT_F2I, 1'b1, RTZ, 32'h0000_0000, nv);
    // -0.25 to unsigned, fine if it rounds to zero
    send(32'hBE80_0000, CVT_F2I, 1'b1, RTZ, 32'd0, flags(1'b0, 1'b1));
    send(32'hBE80_0000, CVT_F2I, 1'b1, RDN, 32'd0, nv);
    send(32'h0000_0000, CVT_F2I, 1'b0, RNE, 32'd0, flags(1'b0, 1'b0));
    send(32'h8000_0000, CVT_F2I, 1'b1, RNE, 32'd0, flags(1'b0, 1'b0));
    for (int i = 0; i < n; i++) begin
      k = int'($urandom_range(5000, 1));
      send(f32_of_real(-real'(k)), CVT_F2I, 1'b1, any_mode(), 32'd0, nv);
    end
  endtask

  task automatic i2f_rounded(input int n);
    data_t  u;
    data_t  want;
    logic   uns;
    logic   nx;
    longint v;
    for (int i = 0; i < n; i++) begin
      u    = $urandom;
      uns  = ($urandom_range(1) == 1);
      v    = uns ? longint'({32'd0, u}) : longint'(int'(u));
      want = f32_of_int(v, nx);
      send(u, CVT_I2F, uns, RNE, want, flags(1'b0, nx));
    end
  endtask

  // Output always ready, every item exactly two cycles
  task automatic flow_burst(input int n);
    drain();
    ready_hold = 1'b1;
    @(negedge clk);
    check_lat = 1'b1;
    i2f_exact(n);
    drain();
    check_lat  = 1'b0;
    ready_hold = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Main sequence

  initial begin : run_tests
    void'($urandom(32'h1417));
    rst_n      = 1'b1;
    in_valid   = 1'b0;
    req        = '0;
    tag_cnt    = '0;
    ready_hold = 1'b0;
    check_lat  = 1'b0;
    #1 rst_n = 1'b0;            // Real falling edge for the async reset
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    assert (in_ready) else fail_event("in_ready_o low after reset");
    assert (!out_valid) else fail_event("out_valid_o high after reset");

    i2f_exact(200);
    f2i_exact(200);
    f2i_trunc(200);
    half_rounding(40);
    f2i_specials(40);
    i2f_rounded(300);
    flow_burst(100);
    drain();

    // Pipe stays empty once every request has returned
    repeat (4) @(posedge clk);
    assert (!out_valid) else fail_event("extra response after the last request returned");
    $display("All checks passed");
    $finish;
  end

  initial begin : watchdog
    #(MAX_OPS * CYC_PER_OP * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d operation slots", MAX_OPS);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- filelist.f
+incdir+include
src/fcvt_pkg.sv
src/fcvt_lzc.sv
src/fcvt_stage_reg.sv
src/fcvt_unpack_norm.sv
src/fcvt_shift_round.sv
src/fcvt_result_sel.sv
src/fcvt_top.sv
testbench/fcvt_tb.sv

//--- Makefile
# Verilator build and run for the binary32 / integer converter

VERILATOR  ?= verilator
TOP        ?= fcvt_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
